//--- hdl/cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

	// ******************************
	// Machine word and ROB indexing
	// ******************************

	typedef logic [31:0] uint32_t;

	localparam int ROB_INDEX_WIDTH = 4;
	localparam int ROB_SIZE        = 1 << ROB_INDEX_WIDTH;  // Sixteen in-flight entries

	typedef logic [ROB_INDEX_WIDTH-1:0] rob_index_t;

	// ******************************
	// Exceptions
	// ******************************

	localparam int EXC_CODE_WIDTH = 5;

	typedef struct packed {
		logic                      valid;
		logic [EXC_CODE_WIDTH-1:0] cause;  // Same encoding as the CP0 Cause.ExcCode field
	} exception_t;

	// ******************************
	// Branch resolution
	// ******************************

	typedef struct packed {
		uint32_t    target;      // Resolved target address
		logic [2:0] kind;        // Jump, call, return or conditional
		logic       taken;
		logic       mispredict;  // Front end guessed wrong
	} branch_resolved_t;

	// ******************************
	// Data memory request
	// ******************************

	typedef struct packed {
		uint32_t    addr;
		logic [3:0] byte_en;
		logic       write;
	} data_memreq_t;

endpackage

`default_nettype wire

//--- hdl/cdb_pkg.sv
`default_nettype none

package cdb_pkg;

	// ******************************
	// Station counts and lanes
	// ******************************

	localparam int ALU_RS_SIZE    = 4;
	localparam int BRANCH_RS_SIZE = 2;
	localparam int LSU_RS_SIZE    = 4;

	localparam int CDB_WIDTH = ALU_RS_SIZE;         // One lane per ALU station
	localparam int CP0_CDB   = BRANCH_RS_SIZE + 1;  // CP0 shares lane 3 with the last ALU

	// All stations plus the single CP0 unit
	localparam int FU_SLOTS = ALU_RS_SIZE + BRANCH_RS_SIZE + LSU_RS_SIZE + 1;

	// ******************************
	// Result payload
	// ******************************

	// The same 37 bits carry a branch outcome or an LSU request
	typedef union packed {
		cpu_types_pkg::branch_resolved_t resolved_branch;
		cpu_types_pkg::data_memreq_t     memreq;
	} cdb_data_t;

	typedef struct packed {
		cpu_types_pkg::rob_index_t reorder;
		cpu_types_pkg::uint32_t    value;
		cpu_types_pkg::exception_t ex;
		cdb_data_t                 data;
	} fu_result_t;

	// ******************************
	// CDB lane
	// ******************************

	typedef struct packed {
		logic                      valid;
		cpu_types_pkg::rob_index_t reorder;
		cpu_types_pkg::uint32_t    value;
		cpu_types_pkg::exception_t ex;
		cdb_data_t                 data;
	} cdb_packet_t;

endpackage

`default_nettype wire

//--- hdl/fu_result_slots.sv
`default_nettype none

module fu_result_slots (
	input  wire logic clk,
	input  wire logic rst,

	input  wire logic [cdb_pkg::ALU_RS_SIZE-1:0]       alu_valid,
	input  wire logic [cdb_pkg::BRANCH_RS_SIZE-1:0]    branch_valid,
	input  wire logic [cdb_pkg::LSU_RS_SIZE-1:0]       lsu_valid,
	input  wire logic                                  cp0_valid,

	input  cdb_pkg::fu_result_t [cdb_pkg::ALU_RS_SIZE-1:0]    alu_in,
	input  cdb_pkg::fu_result_t [cdb_pkg::BRANCH_RS_SIZE-1:0] branch_in,
	input  cdb_pkg::fu_result_t [cdb_pkg::LSU_RS_SIZE-1:0]    lsu_in,
	input  cdb_pkg::fu_result_t                               cp0_in,

	input  wire logic [cdb_pkg::ALU_RS_SIZE-1:0]       alu_ack,
	input  wire logic [cdb_pkg::BRANCH_RS_SIZE-1:0]    branch_ack,
	input  wire logic [cdb_pkg::LSU_RS_SIZE-1:0]       lsu_ack,
	input  wire logic                                  cp0_ack,

	output logic [cdb_pkg::ALU_RS_SIZE-1:0]            alu_ready,
	output logic [cdb_pkg::BRANCH_RS_SIZE-1:0]         branch_ready,
	output logic [cdb_pkg::LSU_RS_SIZE-1:0]            lsu_ready,
	output logic                                       cp0_ready,

	output cdb_pkg::fu_result_t [cdb_pkg::ALU_RS_SIZE-1:0]    alu_held,
	output cdb_pkg::fu_result_t [cdb_pkg::BRANCH_RS_SIZE-1:0] branch_held,
	output cdb_pkg::fu_result_t [cdb_pkg::LSU_RS_SIZE-1:0]    lsu_held,
	output cdb_pkg::fu_result_t                               cp0_held
);

	// ******************************
	// Flattened slot view
	// ******************************

	// Every station is one entry of the same flat array, ALU in the low slots
	// and CP0 in the top one

	logic [cdb_pkg::FU_SLOTS-1:0]                slot_valid;
	logic [cdb_pkg::FU_SLOTS-1:0]                slot_ack;
	logic [cdb_pkg::FU_SLOTS-1:0]                slot_load;
	logic [cdb_pkg::FU_SLOTS-1:0]                slot_full;
	cdb_pkg::fu_result_t [cdb_pkg::FU_SLOTS-1:0] slot_in;
	cdb_pkg::fu_result_t [cdb_pkg::FU_SLOTS-1:0] slot_q;

	assign slot_valid = {cp0_valid, lsu_valid, branch_valid, alu_valid};
	assign slot_ack   = {cp0_ack, lsu_ack, branch_ack, alu_ack};
	assign slot_in    = {cp0_in, lsu_in, branch_in, alu_in};

	// A slot takes a new result when it is empty or drains on this edge
	assign slot_load = slot_valid & (~slot_full | slot_ack);

	// ******************************
	// Slot state
	// ******************************

	always_ff @(posedge clk) begin
		if (rst) begin
			slot_full <= '0;
		end else begin
			slot_full <= slot_load | (slot_full & ~slot_ack);
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < cdb_pkg::FU_SLOTS; i++) begin
			if (slot_load[i]) begin
				slot_q[i] <= slot_in[i];
			end
		end
	end

	// ******************************
	// Back to per-unit groups
	// ******************************

	assign {cp0_ready, lsu_ready, branch_ready, alu_ready} = slot_full;
	assign {cp0_held, lsu_held, branch_held, alu_held}     = slot_q;

endmodule

`default_nettype wire

//--- hdl/cdb_arbitrator.sv
`default_nettype none

module cdb_arbitrator (
	input  cdb_pkg::fu_result_t [cdb_pkg::ALU_RS_SIZE-1:0]    alu_held,
	input  wire logic [cdb_pkg::ALU_RS_SIZE-1:0]              alu_ready,
	output logic [cdb_pkg::ALU_RS_SIZE-1:0]                   alu_ack,

	input  cdb_pkg::fu_result_t [cdb_pkg::BRANCH_RS_SIZE-1:0] branch_held,
	input  wire logic [cdb_pkg::BRANCH_RS_SIZE-1:0]           branch_ready,
	output logic [cdb_pkg::BRANCH_RS_SIZE-1:0]                branch_ack,

	input  cdb_pkg::fu_result_t [cdb_pkg::LSU_RS_SIZE-1:0]    lsu_held,
	input  wire logic [cdb_pkg::LSU_RS_SIZE-1:0]              lsu_ready,
	output logic [cdb_pkg::LSU_RS_SIZE-1:0]                   lsu_ack,

	input  cdb_pkg::fu_result_t                               cp0_held,
	input  wire logic                                         cp0_ready,
	output logic                                              cp0_ack,

	output cdb_pkg::cdb_packet_t [cdb_pkg::CDB_WIDTH-1:0]     cdb_next
);

	// Fields a unit does not produce are driven to zero on the bus
	function automatic cdb_pkg::cdb_packet_t make_packet(
		input cdb_pkg::fu_result_t rec,
		input logic                keep_ex,
		input logic                keep_data
	);
		cdb_pkg::cdb_packet_t pkt;

		pkt         = '0;
		pkt.valid   = 1'b1;
		pkt.reorder = rec.reorder;
		pkt.value   = rec.value;
		if (keep_ex) begin
			pkt.ex = rec.ex;
		end
		if (keep_data) begin
			pkt.data = rec.data;
		end
		return pkt;
	endfunction

	// ******************************
	// Lane priority
	// ******************************

	// Each stage below overrides the one before it, so the last writer of a
	// lane is the highest priority unit that is ready

	always_comb begin
		cdb_next   = '0;
		alu_ack    = '0;
		branch_ack = '0;
		lsu_ack    = '0;
		cp0_ack    = 1'b0;

		for (int i = 0; i < cdb_pkg::ALU_RS_SIZE; i++) begin
			alu_ack[i] = alu_ready[i];
			if (alu_ready[i]) begin
				cdb_next[i] = make_packet(alu_held[i], 1'b1, 1'b0);
			end
		end

		for (int i = 0; i < cdb_pkg::BRANCH_RS_SIZE; i++) begin
			if (branch_ready[i]) begin
				branch_ack[i] = 1'b1;
				alu_ack[i]    = 1'b0;
				cdb_next[i]   = make_packet(branch_held[i], 1'b0, 1'b1);  // Never excepts
			end
		end

		if (cp0_ready) begin
			cp0_ack                   = 1'b1;
			alu_ack[cdb_pkg::CP0_CDB] = 1'b0;
			cdb_next[cdb_pkg::CP0_CDB] = make_packet(cp0_held, 1'b1, 1'b0);
		end

		for (int i = 0; i < cdb_pkg::LSU_RS_SIZE; i++) begin
			if (lsu_ready[i]) begin
				lsu_ack[i] = 1'b1;
				alu_ack[i] = 1'b0;
				if (i == cdb_pkg::CP0_CDB) begin
					cp0_ack = 1'b0;
				end
				cdb_next[i] = make_packet(lsu_held[i], 1'b1, 1'b1);
			end
		end

		// Branch lanes lost to a load/store
		for (int i = 0; i < cdb_pkg::BRANCH_RS_SIZE; i++) begin
			if (lsu_ready[i]) begin
				branch_ack[i] = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/rob_completion.sv
`default_nettype none

module rob_completion (
	input  wire logic                                     clk,
	input  wire logic                                     rst,

	input  cdb_pkg::cdb_packet_t [cdb_pkg::CDB_WIDTH-1:0] cdb_next,

	input  wire logic                                     retire,
	input  cpu_types_pkg::rob_index_t                     retire_index,

	output cdb_pkg::cdb_packet_t [cdb_pkg::CDB_WIDTH-1:0] cdb,
	output logic [cpu_types_pkg::ROB_SIZE-1:0]            rob_done,
	output logic [cpu_types_pkg::ROB_SIZE-1:0]            rob_exception
);

	logic [cpu_types_pkg::ROB_SIZE-1:0] done_d;
	logic [cpu_types_pkg::ROB_SIZE-1:0] exception_d;

	// ******************************
	// Outgoing CDB register
	// ******************************

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < cdb_pkg::CDB_WIDTH; i++) begin
				cdb[i].valid <= 1'b0;
			end
		end else begin
			cdb <= cdb_next;
		end
	end

	// ******************************
	// Completion status table
	// ******************************

	always_comb begin
		done_d      = rob_done;
		exception_d = rob_exception;

		if (retire) begin
			done_d[retire_index]      = 1'b0;
			exception_d[retire_index] = 1'b0;
		end

		// Applied after the retire clear so a same-cycle completion survives
		for (int i = 0; i < cdb_pkg::CDB_WIDTH; i++) begin
			if (cdb_next[i].valid) begin
				done_d[cdb_next[i].reorder] = 1'b1;
				if (cdb_next[i].ex.valid) begin
					exception_d[cdb_next[i].reorder] = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rob_done      <= '0;
			rob_exception <= '0;
		end else begin
			rob_done      <= done_d;
			rob_exception <= exception_d;
		end
	end

endmodule

`default_nettype wire

//--- hdl/cdb_top.sv
`default_nettype none

module cdb_top (
	input  wire logic                                         clk,
	input  wire logic                                         rst,

	input  wire logic [cdb_pkg::ALU_RS_SIZE-1:0]              alu_valid,
	input  wire logic [cdb_pkg::BRANCH_RS_SIZE-1:0]           branch_valid,
	input  wire logic [cdb_pkg::LSU_RS_SIZE-1:0]              lsu_valid,
	input  wire logic                                         cp0_valid,

	input  cdb_pkg::fu_result_t [cdb_pkg::ALU_RS_SIZE-1:0]    alu_in,
	input  cdb_pkg::fu_result_t [cdb_pkg::BRANCH_RS_SIZE-1:0] branch_in,
	input  cdb_pkg::fu_result_t [cdb_pkg::LSU_RS_SIZE-1:0]    lsu_in,
	input  cdb_pkg::fu_result_t                               cp0_in,

	output logic [cdb_pkg::ALU_RS_SIZE-1:0]                   alu_busy,
	output logic [cdb_pkg::BRANCH_RS_SIZE-1:0]                branch_busy,
	output logic [cdb_pkg::LSU_RS_SIZE-1:0]                   lsu_busy,
	output logic                                              cp0_busy,

	input  wire logic                                         retire,
	input  cpu_types_pkg::rob_index_t                         retire_index,

	output cdb_pkg::cdb_packet_t [cdb_pkg::CDB_WIDTH-1:0]     cdb,
	output logic [cpu_types_pkg::ROB_SIZE-1:0]                rob_done,
	output logic [cpu_types_pkg::ROB_SIZE-1:0]                rob_exception
);

	// ******************************
	// Slot to arbitrator wiring
	// ******************************

	cdb_pkg::fu_result_t [cdb_pkg::ALU_RS_SIZE-1:0]    alu_held;
	cdb_pkg::fu_result_t [cdb_pkg::BRANCH_RS_SIZE-1:0] branch_held;
	cdb_pkg::fu_result_t [cdb_pkg::LSU_RS_SIZE-1:0]    lsu_held;
	cdb_pkg::fu_result_t                               cp0_held;

	logic [cdb_pkg::ALU_RS_SIZE-1:0]    alu_ack;
	logic [cdb_pkg::BRANCH_RS_SIZE-1:0] branch_ack;
	logic [cdb_pkg::LSU_RS_SIZE-1:0]    lsu_ack;
	logic                               cp0_ack;

	cdb_pkg::cdb_packet_t [cdb_pkg::CDB_WIDTH-1:0] cdb_next;

	fu_result_slots i_slots (
		.clk          (clk),
		.rst          (rst),
		.alu_valid    (alu_valid),
		.branch_valid (branch_valid),
		.lsu_valid    (lsu_valid),
		.cp0_valid    (cp0_valid),
		.alu_in       (alu_in),
		.branch_in    (branch_in),
		.lsu_in       (lsu_in),
		.cp0_in       (cp0_in),
		.alu_ack      (alu_ack),
		.branch_ack   (branch_ack),
		.lsu_ack      (lsu_ack),
		.cp0_ack      (cp0_ack),
		.alu_ready    (alu_busy),     // A full slot is what the unit sees as busy
		.branch_ready (branch_busy),
		.lsu_ready    (lsu_busy),
		.cp0_ready    (cp0_busy),
		.alu_held     (alu_held),
		.branch_held  (branch_held),
		.lsu_held     (lsu_held),
		.cp0_held     (cp0_held)
	);

	cdb_arbitrator i_arbitrator (
		.alu_held     (alu_held),
		.alu_ready    (alu_busy),
		.alu_ack      (alu_ack),
		.branch_held  (branch_held),
		.branch_ready (branch_busy),
		.branch_ack   (branch_ack),
		.lsu_held     (lsu_held),
		.lsu_ready    (lsu_busy),
		.lsu_ack      (lsu_ack),
		.cp0_held     (cp0_held),
		.cp0_ready    (cp0_busy),
		.cp0_ack      (cp0_ack),
		.cdb_next     (cdb_next)
	);

	rob_completion i_completion (
		.clk           (clk),
		.rst           (rst),
		.cdb_next      (cdb_next),
		.retire        (retire),
		.retire_index  (retire_index),
		.cdb           (cdb),
		.rob_done      (rob_done),
		.rob_exception (rob_exception)
	);

endmodule

`default_nettype wire

//--- bench/cdb_tb.sv
`default_nettype none

module cdb_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int FU_COUNT      = cdb_pkg::FU_SLOTS;
	localparam int BRANCH_BASE   = cdb_pkg::ALU_RS_SIZE;
	localparam int LSU_BASE      = BRANCH_BASE + cdb_pkg::BRANCH_RS_SIZE;
	localparam int CP0_BASE      = LSU_BASE + cdb_pkg::LSU_RS_SIZE;
	localparam int RANDOM_CYCLES = 400;
	localparam int MAX_CYCLES    = 2000;  // Directed tests take under 200 cycles and random ones 400

	logic clk;
	logic rst;
	logic [cdb_pkg::ALU_RS_SIZE-1:0]    alu_valid;
	logic [cdb_pkg::BRANCH_RS_SIZE-1:0] branch_valid;
	logic [cdb_pkg::LSU_RS_SIZE-1:0]    lsu_valid;
	logic                               cp0_valid;
	cdb_pkg::fu_result_t [cdb_pkg::ALU_RS_SIZE-1:0]    alu_in;
	cdb_pkg::fu_result_t [cdb_pkg::BRANCH_RS_SIZE-1:0] branch_in;
	cdb_pkg::fu_result_t [cdb_pkg::LSU_RS_SIZE-1:0]    lsu_in;
	cdb_pkg::fu_result_t                               cp0_in;
	logic [cdb_pkg::ALU_RS_SIZE-1:0]    alu_busy;
	logic [cdb_pkg::BRANCH_RS_SIZE-1:0] branch_busy;
	logic [cdb_pkg::LSU_RS_SIZE-1:0]    lsu_busy;
	logic                               cp0_busy;
	logic                               retire;
	cpu_types_pkg::rob_index_t          retire_index;
	cdb_pkg::cdb_packet_t [cdb_pkg::CDB_WIDTH-1:0] cdb;
	logic [cpu_types_pkg::ROB_SIZE-1:0] rob_done;
	logic [cpu_types_pkg::ROB_SIZE-1:0] rob_exception;

	// Reference model state in slot order ALU, branch, LSU and CP0
	logic [FU_COUNT-1:0]                           model_full;
	cdb_pkg::fu_result_t [FU_COUNT-1:0]            model_rec;
	cdb_pkg::cdb_packet_t [cdb_pkg::CDB_WIDTH-1:0] exp_cdb;
	logic [cpu_types_pkg::ROB_SIZE-1:0]            exp_done;
	logic [cpu_types_pkg::ROB_SIZE-1:0]            exp_exc;
	logic [FU_COUNT-1:0]                           busy_all;
	string test_name = "reset";
	int    strobe_count = 0;
	int    broadcast_count = 0;
	int    cycle_count = 0;

	assign busy_all = {cp0_busy, lsu_busy, branch_busy, alu_busy};

	cdb_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic report_mismatch(input string name, input string what,
			input logic [127:0] expected, input logic [127:0] actual);
		$display("[ERROR] %s: %s expected %h actual %h", name, what, expected, actual);
		$display("test failed");
		$fatal(1, "stopping at first error");
	endtask

	function automatic cdb_pkg::fu_result_t random_result(input logic as_branch);
		cdb_pkg::fu_result_t r;
		logic [31:0]         w0;
		logic [31:0]         w1;
		logic [31:0]         w2;
		w0 = $urandom;
		w1 = $urandom;
		w2 = $urandom;
		r.reorder  = w0[3:0];
		r.value    = w1;
		r.ex.valid = (w0[5:4] == 2'd0);  // About one result in four excepts
		r.ex.cause = w0[12:8];
		if (as_branch) begin
			r.data.resolved_branch.target     = w2;
			r.data.resolved_branch.kind       = w0[15:13];
			r.data.resolved_branch.taken      = w0[16];
			r.data.resolved_branch.mispredict = w0[17];
		end else begin
			r.data.memreq.addr    = w2;
			r.data.memreq.byte_en = w0[21:18];
			r.data.memreq.write   = w0[22];
		end
		return r;
	endfunction

	task automatic present_results();
		for (int i = 0; i < cdb_pkg::ALU_RS_SIZE; i++) alu_in[i] <= random_result(1'b0);
		for (int i = 0; i < cdb_pkg::BRANCH_RS_SIZE; i++) branch_in[i] <= random_result(1'b1);
		for (int i = 0; i < cdb_pkg::LSU_RS_SIZE; i++) lsu_in[i] <= random_result(1'b0);
		cp0_in <= random_result(1'b0);
	endtask

	task automatic drive_strobes(input logic [cdb_pkg::ALU_RS_SIZE-1:0] alu,
			input logic [cdb_pkg::BRANCH_RS_SIZE-1:0] branch,
			input logic [cdb_pkg::LSU_RS_SIZE-1:0] lsu, input logic cp0);
		@(posedge clk);
		present_results();
		alu_valid    <= alu;
		branch_valid <= branch;
		lsu_valid    <= lsu;
		cp0_valid    <= cp0;
	endtask

	task automatic clear_strobes();
		@(posedge clk);
		alu_valid    <= '0;
		branch_valid <= '0;
		lsu_valid    <= '0;
		cp0_valid    <= 1'b0;
		retire       <= 1'b0;
	endtask

	task automatic wait_drain();
		@(posedge clk);
		while (|model_full) @(posedge clk);
		repeat (2) @(posedge clk);  // Last broadcast reaches cdb and gets checked
	endtask

	// ******************************
	// Reference model
	// ******************************

	always @(posedge clk) begin : model_step
		logic [FU_COUNT-1:0]                           strobe;
		logic [FU_COUNT-1:0]                           ack;
		logic [FU_COUNT-1:0]                           load;
		cdb_pkg::fu_result_t [FU_COUNT-1:0]            incoming;
		cdb_pkg::cdb_packet_t [cdb_pkg::CDB_WIDTH-1:0] pkts;
		logic [cpu_types_pkg::ROB_SIZE-1:0]            done_n;
		logic [cpu_types_pkg::ROB_SIZE-1:0]            exc_n;
		int                                            win;
		if (rst) begin
			model_full <= '0;
			exp_cdb    <= '0;
			exp_done   <= '0;
			exp_exc    <= '0;
		end else begin
			strobe   = {cp0_valid, lsu_valid, branch_valid, alu_valid};
			incoming = {cp0_in, lsu_in, branch_in, alu_in};
			ack      = '0;
			pkts     = '0;
			for (int l = 0; l < cdb_pkg::CDB_WIDTH; l++) begin
				win = -1;
				if (l < cdb_pkg::LSU_RS_SIZE && model_full[LSU_BASE + l]) begin
					win = LSU_BASE + l;
				end else if (l == cdb_pkg::CP0_CDB && model_full[CP0_BASE]) begin
					win = CP0_BASE;
				end else if (l < cdb_pkg::BRANCH_RS_SIZE && model_full[BRANCH_BASE + l]) begin
					win = BRANCH_BASE + l;
				end else if (model_full[l]) begin
					win = l;
				end
				if (win >= 0) begin
					ack[win]        = 1'b1;
					pkts[l].valid   = 1'b1;
					pkts[l].reorder = model_rec[win].reorder;
					pkts[l].value   = model_rec[win].value;
					if (win < BRANCH_BASE || win >= LSU_BASE) begin
						pkts[l].ex = model_rec[win].ex;  // Branches carry no exception
					end
					if (win >= BRANCH_BASE && win < CP0_BASE) begin
						pkts[l].data = model_rec[win].data;  // Only branch and LSU fill data
					end
				end
			end
			load = strobe & (~model_full | ack);
			for (int i = 0; i < FU_COUNT; i++) begin
				if (load[i]) model_rec[i] <= incoming[i];
			end
			done_n = exp_done;
			exc_n  = exp_exc;
			if (retire) begin
				done_n[retire_index] = 1'b0;
				exc_n[retire_index]  = 1'b0;
			end
			for (int l = 0; l < cdb_pkg::CDB_WIDTH; l++) begin
				if (pkts[l].valid) begin
					done_n[pkts[l].reorder] = 1'b1;
					if (pkts[l].ex.valid) exc_n[pkts[l].reorder] = 1'b1;
				end
			end
			model_full <= load | (model_full & ~ack);
			exp_cdb    <= pkts;
			exp_done   <= done_n;
			exp_exc    <= exc_n;
		end
	end

	// The random phase starts with every slot and lane empty
	always @(posedge clk) begin
		if (!rst && test_name == "random_traffic") begin
			strobe_count += $countones({cp0_valid, lsu_valid, branch_valid, alu_valid});
			for (int l = 0; l < cdb_pkg::CDB_WIDTH; l++) begin
				if (cdb[l].valid) broadcast_count++;
			end
		end
	end

	// ******************************
	// Checks
	// ******************************

	for (genvar l = 0; l < cdb_pkg::CDB_WIDTH; l++) begin : g_lane
		lane_match: assert property (@(posedge clk) disable iff (rst)
			cdb[l].valid == exp_cdb[l].valid && (!exp_cdb[l].valid || cdb[l] == exp_cdb[l]))
		else report_mismatch(test_name, $sformatf("cdb lane %0d", l),
			$sampled(exp_cdb[l]), $sampled(cdb[l]));
	end

	busy_match: assert property (@(posedge clk) disable iff (rst) busy_all == model_full)
		else report_mismatch(test_name, "busy", $sampled(model_full), $sampled(busy_all));

	flags_match: assert property (@(posedge clk) disable iff (rst)
		{rob_exception, rob_done} == {exp_exc, exp_done})
		else report_mismatch(test_name, "rob exception and done", $sampled({exp_exc, exp_done}),
			$sampled({rob_exception, rob_done}));

	initial begin
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
		$display("test failed");
		$fatal(1, "timeout");
	end

	// ******************************
	// Stimulus
	// ******************************

	initial begin
		cdb_pkg::fu_result_t rec;
		logic [31:0]         r;
		void'($urandom(74856));
		rst          = 1'b1;
		alu_valid    = '0;
		branch_valid = '0;
		lsu_valid    = '0;
		cp0_valid    = 1'b0;
		alu_in       = '0;
		branch_in    = '0;
		lsu_in       = '0;
		cp0_in       = '0;
		retire       = 1'b0;
		retire_index = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		test_name = "alu_alone";
		drive_strobes('1, '0, '0, 1'b0);
		clear_strobes();
		wait_drain();
		test_name = "branch_vs_alu";
		drive_strobes(4'b0011, '1, '0, 1'b0);
		clear_strobes();
		wait_drain();
		test_name = "cp0_vs_alu";
		drive_strobes('1, '0, '0, 1'b1);
		clear_strobes();
		wait_drain();
		test_name = "lsu_vs_all";
		drive_strobes('1, '1, '1, 1'b1);
		clear_strobes();
		wait_drain();
		test_name = "strobe_while_busy";
		drive_strobes(4'b0001, 2'b01, '0, 1'b0);
		drive_strobes(4'b0001, '0, '0, 1'b0);  // Slot 0 still holds the first result
		clear_strobes();
		wait_drain();
		test_name = "rob_flags";
		rec          = random_result(1'b0);
		rec.reorder  = 4'd9;
		rec.ex.valid = 1'b1;
		@(posedge clk);
		alu_in[2]    <= rec;
		alu_valid    <= 4'b0100;
		clear_strobes();
		wait_drain();
		@(posedge clk);
		retire       <= 1'b1;
		retire_index <= 4'd9;
		clear_strobes();
		@(posedge clk);
		alu_in[2]    <= rec;
		alu_valid    <= 4'b0100;
		@(posedge clk);
		alu_valid    <= '0;
		retire       <= 1'b1;  // Meets the completion of entry 9 on the same edge
		retire_index <= 4'd9;
		clear_strobes();
		wait_drain();
		test_name = "random_traffic";
		repeat (RANDOM_CYCLES) begin
			@(posedge clk);
			r = $urandom;
			present_results();
			alu_valid    <= r[3:0] & ~alu_busy & ~alu_valid;
			branch_valid <= r[5:4] & ~branch_busy & ~branch_valid;
			lsu_valid    <= r[9:6] & ~lsu_busy & ~lsu_valid;
			cp0_valid    <= r[10] & ~cp0_busy & ~cp0_valid;
			retire       <= r[11];
			retire_index <= r[15:12];
		end
		clear_strobes();
		wait_drain();
		@(negedge clk);
		if (strobe_count != broadcast_count) begin
			report_mismatch(test_name, "broadcast count", strobe_count, broadcast_count);
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- project.f
hdl/cpu_types_pkg.sv
hdl/cdb_pkg.sv
hdl/fu_result_slots.sv
hdl/cdb_arbitrator.sv
hdl/rob_completion.sv
hdl/cdb_top.sv
bench/cdb_tb.sv

//--- Bender.yml
package:
  name: cdb_writeback

sources:
  - hdl/cpu_types_pkg.sv
  - hdl/cdb_pkg.sv
  - hdl/fu_result_slots.sv
  - hdl/cdb_arbitrator.sv
  - hdl/rob_completion.sv
  - hdl/cdb_top.sv
  - target: test
    files:
      - bench/cdb_tb.sv
